// File: source/main_bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main bus definitions
// widths, memory map and I/O port layout of the main CPU bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package main_bus_pkg;

    typedef logic [23:1] cpu_addr_t;    // word address, byte bit dropped
    typedef logic [15:0] cpu_data_t;
    typedef logic [13:0] ram_addr_t;    // 16K words
    typedef logic [7:0]  byte_t;
    typedef logic [9:0]  io_sel_t;      // one-hot port select

    // map fields of the byte address
    localparam logic [8:0] RAM_BASE = 9'h041;   // addr[23:15] of 0x208000
    localparam logic [3:0] GCU_PAGE = 4'h4;     // addr[23:20]
    localparam logic [3:0] IO_PAGE  = 4'h5;

    // bit positions in io_sel_t
    localparam int IO_IN     = 0;
    localparam int IO_SYS    = 1;
    localparam int IO_DSW    = 2;
    localparam int IO_VCOUNT = 3;
    localparam int IO_SL3    = 4;
    localparam int IO_SL4    = 5;
    localparam int IO_SL1W   = 6;
    localparam int IO_SL2W   = 7;
    localparam int IO_EEPR   = 8;
    localparam int IO_EEPW   = 9;

    // byte offsets in the I/O page
    localparam logic [7:0] IO_OFS_IN     = 8'h00;
    localparam logic [7:0] IO_OFS_SYS    = 8'h02;
    localparam logic [7:0] IO_OFS_DSW    = 8'h04;
    localparam logic [7:0] IO_OFS_VCOUNT = 8'h06;
    localparam logic [7:0] IO_OFS_SL3    = 8'h10;
    localparam logic [7:0] IO_OFS_SL4    = 8'h12;
    localparam logic [7:0] IO_OFS_SL1W   = 8'h14;
    localparam logic [7:0] IO_OFS_SL2W   = 8'h16;
    localparam logic [7:0] IO_OFS_EEPR   = 8'h18;
    localparam logic [7:0] IO_OFS_EEPW   = 8'h1E;

    // GCU register offsets
    localparam logic [3:0] GCU_OFS_WREG   = 4'h0;
    localparam logic [3:0] GCU_OFS_SEL    = 4'h4;
    localparam logic [3:0] GCU_OFS_DATA_H = 4'h8;
    localparam logic [3:0] GCU_OFS_DATA_L = 4'hA;
    localparam logic [3:0] GCU_OFS_PTR    = 4'hC;

endpackage

`default_nettype wire

// File: source/cpu_bus_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus cycle
// address, data and strobes of one 68000-style access
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface cpu_bus_if;
    import main_bus_pkg::*;

    cpu_addr_t addr;
    cpu_data_t wdata;
    logic      rw;      // high for read
    logic      uds_n;
    logic      lds_n;
    logic      as_n;

    modport decoder (input addr, wdata, rw, uds_n, lds_n, as_n);
    modport ram     (input addr, wdata, rw, uds_n, lds_n);
    modport reader  (input addr);
    modport writer  (input addr, wdata, lds_n);

endinterface

`default_nettype wire

// File: source/address_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main bus address decoder
// registers region and I/O port selects one cycle into the access,
// marks the first decoded cycle and times the data acknowledge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module address_decoder (
    input  logic                  CLK96,
    input  logic                  RESET96,
    cpu_bus_if.decoder            bus,
    input  logic                  gcu_ack,
    output logic                  sel_ram,
    output logic                  sel_gcu,
    output main_bus_pkg::io_sel_t sel_io,
    output logic                  access_new,
    output logic                  dtack_n
);
    import main_bus_pkg::*;

    logic [23:0] byte_addr;
    logic        as_d;      // as_n one edge back
    logic        cyc;       // address phase already seen on the last edge
    logic        acc;       // decoded access in progress
    logic        wr_lo;
    io_sel_t     io_hit;

    assign byte_addr = {bus.addr, 1'b0};
    assign cyc       = !bus.as_n && !as_d && !(bus.uds_n && bus.lds_n);
    assign wr_lo     = !bus.rw && !bus.lds_n;

    // port match inside the I/O page, mirrored above 0xFF
    always_comb begin
        io_hit[IO_IN]     = byte_addr[7:0] == IO_OFS_IN;
        io_hit[IO_SYS]    = byte_addr[7:0] == IO_OFS_SYS;
        io_hit[IO_DSW]    = byte_addr[7:0] == IO_OFS_DSW;
        io_hit[IO_VCOUNT] = byte_addr[7:0] == IO_OFS_VCOUNT;
        io_hit[IO_SL3]    = byte_addr[7:0] == IO_OFS_SL3;
        io_hit[IO_SL4]    = byte_addr[7:0] == IO_OFS_SL4;
        io_hit[IO_SL1W]   = byte_addr[7:0] == IO_OFS_SL1W && wr_lo;   // low lane only
        io_hit[IO_SL2W]   = byte_addr[7:0] == IO_OFS_SL2W && wr_lo;
        io_hit[IO_EEPR]   = byte_addr[7:0] == IO_OFS_EEPR && bus.rw;
        io_hit[IO_EEPW]   = byte_addr[7:0] == IO_OFS_EEPW && !bus.rw;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            as_d       <= 1'b1;
            acc        <= 1'b0;
            sel_ram    <= 1'b0;
            sel_gcu    <= 1'b0;
            sel_io     <= '0;
            access_new <= 1'b0;
            dtack_n    <= 1'b1;
        end else begin
            as_d       <= bus.as_n;
            acc        <= cyc;
            access_new <= cyc && !acc;      // first decoded cycle only
            sel_ram    <= cyc && byte_addr[23:15] == RAM_BASE;
            sel_gcu    <= cyc && byte_addr[23:20] == GCU_PAGE;
            sel_io     <= (cyc && byte_addr[23:20] == IO_PAGE) ? io_hit : '0;

            if (bus.as_n) begin
                dtack_n <= 1'b1;
            end else if (acc && !sel_gcu) begin
                dtack_n <= 1'b0;            // RAM, I/O and unmapped space
            end else if (sel_gcu && gcu_ack && !access_new) begin
                dtack_n <= 1'b0;            // GCU has taken the op
            end
        end
    end

endmodule

`default_nettype wire

// File: source/work_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main CPU work RAM
// 16K x 16 with byte-lane writes and a registered read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module work_ram (
    input  logic                    CLK96,
    cpu_bus_if.ram                  bus,
    input  logic                    sel_ram,
    output main_bus_pkg::cpu_data_t ram_q
);
    import main_bus_pkg::*;

    cpu_data_t mem [0:16383];
    ram_addr_t ram_addr;
    logic      we;

    assign ram_addr = bus.addr[14:1];     // 0x208000 window folds to 32K bytes
    assign we       = sel_ram && !bus.rw;

    always_ff @(posedge CLK96) begin
        if (we && !bus.uds_n) begin
            mem[ram_addr][15:8] <= bus.wdata[15:8];
        end
        if (we && !bus.lds_n) begin
            mem[ram_addr][7:0] <= bus.wdata[7:0];
        end
        ram_q <= mem[ram_addr];
    end

endmodule

`default_nettype wire

// File: source/io_read_mux.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main bus read data
// formats cabinet, DIP and video status words and registers the word
// the CPU sees from RAM, GCU or I/O page
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module io_read_mux (
    input  logic                    CLK96,
    input  logic                    RESET96,
    cpu_bus_if.reader               bus,
    input  logic                    sel_ram,
    input  logic                    sel_gcu,
    input  main_bus_pkg::io_sel_t   sel_io,
    input  main_bus_pkg::cpu_data_t ram_q,
    input  main_bus_pkg::cpu_data_t gcu_rdata,
    input  logic [9:0]              joystick1,
    input  logic [9:0]              joystick2,
    input  logic [3:0]              start_button,
    input  logic [3:0]              coin_input,
    input  logic                    service,
    input  logic                    dip_test,
    input  main_bus_pkg::byte_t     dipsw_a,
    input  main_bus_pkg::byte_t     dipsw_b,
    input  main_bus_pkg::byte_t     dipsw_c,
    input  main_bus_pkg::byte_t     soundlatch3,
    input  main_bus_pkg::byte_t     soundlatch4,
    input  logic                    hsync,
    input  logic                    vsync,
    input  logic                    fblank,
    input  logic [8:0]              vcount,
    input  logic                    eeprom_sdo,
    input  logic                    z80_busreq,
    output main_bus_pkg::cpu_data_t rdata
);
    import main_bus_pkg::*;

    logic [3:0] gcu_ofs;
    logic       gcu_data;   // data port of the GCU
    byte_t      sys_lo;
    byte_t      vpos;
    cpu_data_t  video_word;
    cpu_data_t  io_word;

    // cabinet inputs are active low, the game wants them active high
    function automatic byte_t player_byte(input logic [9:0] joy);
        player_byte = {1'b0, ~joy[6], ~joy[5], ~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
    endfunction

    assign gcu_ofs  = {bus.addr[3:1], 1'b0};
    assign gcu_data = gcu_ofs == GCU_OFS_DATA_H || gcu_ofs == GCU_OFS_DATA_L;

    assign sys_lo = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                     ~coin_input[0], ~dip_test, 1'b0, ~service};

    assign vpos       = vcount[8] ? 8'hFF : vcount[7:0];   // clamp past line 255
    assign video_word = {hsync, vsync, 5'b11111, fblank, vpos};

    always_comb begin
        case (1'b1)
            sel_io[IO_IN]:     io_word = {player_byte(joystick2), player_byte(joystick1)};
            sel_io[IO_SYS]:    io_word = {dipsw_c, sys_lo};
            sel_io[IO_DSW]:    io_word = {dipsw_b, dipsw_a};
            sel_io[IO_VCOUNT]: io_word = video_word;
            sel_io[IO_SL3]:    io_word = {8'h00, soundlatch3};
            sel_io[IO_SL4]:    io_word = {8'h00, soundlatch4};
            sel_io[IO_EEPR]:   io_word = {11'h000, eeprom_sdo, 3'b000, z80_busreq};
            default:           io_word = '0;    // write ports and holes
        endcase
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            rdata <= '0;
        end else if (sel_gcu) begin
            rdata <= gcu_data ? gcu_rdata : '0;
        end else if (sel_ram) begin
            rdata <= ram_q;
        end else begin
            rdata <= io_word;
        end
    end

endmodule

`default_nettype wire

// File: source/io_write_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main bus write ports
// sound latches with NMI, EEPROM pins and the GCU op strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module io_write_regs (
    input  logic                  CLK96,
    input  logic                  RESET96,
    cpu_bus_if.writer             bus,
    input  logic                  sel_gcu,
    input  logic                  rw,
    input  logic                  access_new,
    input  main_bus_pkg::io_sel_t sel_io,
    input  logic                  gcu_ack,
    output main_bus_pkg::byte_t   soundlatch,
    output main_bus_pkg::byte_t   soundlatch2,
    output logic                  nmi,
    output logic                  eeprom_sclk,
    output logic                  eeprom_sdi,
    output logic                  eeprom_scs,
    output logic                  z80_busreq,
    output logic                  gcu_op_write_reg,
    output logic                  gcu_op_select_reg,
    output logic                  gcu_op_write_ram,
    output logic                  gcu_op_read_h,
    output logic                  gcu_op_read_l,
    output logic                  gcu_op_set_ptr
);
    import main_bus_pkg::*;

    logic [3:0] gcu_ofs;
    logic       sl1_wr;
    logic       sl2_wr;
    logic       eep_wr;
    logic       gcu_go;

    assign gcu_ofs = {bus.addr[3:1], 1'b0};
    assign sl1_wr  = access_new && sel_io[IO_SL1W];
    assign sl2_wr  = access_new && sel_io[IO_SL2W];
    assign eep_wr  = access_new && sel_io[IO_EEPW] && !bus.lds_n;
    assign gcu_go  = access_new && sel_gcu;

    always_ff @(posedge CLK96) begin
        if (sl1_wr) begin
            soundlatch <= bus.wdata[7:0];
        end
        if (sl2_wr) begin
            soundlatch2 <= bus.wdata[7:0];
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            nmi               <= 1'b0;
            z80_busreq        <= 1'b0;
            eeprom_sclk       <= 1'b0;
            eeprom_sdi        <= 1'b0;
            eeprom_scs        <= 1'b0;
            gcu_op_write_reg  <= 1'b0;
            gcu_op_select_reg <= 1'b0;
            gcu_op_write_ram  <= 1'b0;
            gcu_op_read_h     <= 1'b0;
            gcu_op_read_l     <= 1'b0;
            gcu_op_set_ptr    <= 1'b0;
        end else begin
            nmi <= sl1_wr || sl2_wr;    // one cycle per latch write

            if (eep_wr) begin
                z80_busreq  <= bus.wdata[4];
                eeprom_sclk <= bus.wdata[3];
                eeprom_sdi  <= bus.wdata[2];
                eeprom_scs  <= bus.wdata[0];
            end

            // strobe held until the GCU answers
            if (gcu_go) begin
                gcu_op_write_reg  <= !rw && gcu_ofs == GCU_OFS_WREG;
                gcu_op_select_reg <= !rw && gcu_ofs == GCU_OFS_SEL;
                gcu_op_write_ram  <= !rw && (gcu_ofs == GCU_OFS_DATA_H ||
                                             gcu_ofs == GCU_OFS_DATA_L);
                gcu_op_read_h     <= rw && gcu_ofs == GCU_OFS_DATA_H;
                gcu_op_read_l     <= rw && gcu_ofs == GCU_OFS_DATA_L;
                gcu_op_set_ptr    <= !rw && gcu_ofs == GCU_OFS_PTR;
            end else if (gcu_ack) begin
                gcu_op_write_reg  <= 1'b0;
                gcu_op_select_reg <= 1'b0;
                gcu_op_write_ram  <= 1'b0;
                gcu_op_read_h     <= 1'b0;
                gcu_op_read_l     <= 1'b0;
                gcu_op_set_ptr    <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/main_bus.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main CPU bus glue
// decodes the 68000 bus onto work RAM, the GCU window and the I/O page
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module main_bus (
    input  logic                    CLK96,
    input  logic                    RESET96,
    // CPU side
    input  main_bus_pkg::cpu_addr_t addr,
    input  main_bus_pkg::cpu_data_t wdata,
    input  logic                    rw,
    input  logic                    uds_n,
    input  logic                    lds_n,
    input  logic                    as_n,
    output main_bus_pkg::cpu_data_t rdata,
    output logic                    dtack_n,
    // cabinet and video
    input  logic [9:0]              joystick1,
    input  logic [9:0]              joystick2,
    input  logic [3:0]              start_button,
    input  logic [3:0]              coin_input,
    input  logic                    service,
    input  logic                    dip_test,
    input  main_bus_pkg::byte_t     dipsw_a,
    input  main_bus_pkg::byte_t     dipsw_b,
    input  main_bus_pkg::byte_t     dipsw_c,
    input  logic                    hsync,
    input  logic                    vsync,
    input  logic                    fblank,
    input  logic [8:0]              vcount,
    // sound CPU
    input  main_bus_pkg::byte_t     soundlatch3,
    input  main_bus_pkg::byte_t     soundlatch4,
    output main_bus_pkg::byte_t     soundlatch,
    output main_bus_pkg::byte_t     soundlatch2,
    output logic                    nmi,
    output logic                    z80_busreq,
    // EEPROM
    output logic                    eeprom_sclk,
    output logic                    eeprom_sdi,
    input  logic                    eeprom_sdo,
    output logic                    eeprom_scs,
    // GCU
    input  logic                    gcu_ack,
    input  main_bus_pkg::cpu_data_t gcu_rdata,
    output logic                    gcu_op_write_reg,
    output logic                    gcu_op_select_reg,
    output logic                    gcu_op_write_ram,
    output logic                    gcu_op_read_h,
    output logic                    gcu_op_read_l,
    output logic                    gcu_op_set_ptr
);
    import main_bus_pkg::*;

    logic      sel_ram;
    logic      sel_gcu;
    io_sel_t   sel_io;
    logic      access_new;
    cpu_data_t ram_q;

    cpu_bus_if bus ();

    assign bus.addr  = addr;
    assign bus.wdata = wdata;
    assign bus.rw    = rw;
    assign bus.uds_n = uds_n;
    assign bus.lds_n = lds_n;
    assign bus.as_n  = as_n;

    address_decoder u_decoder (
        .CLK96      (CLK96),
        .RESET96    (RESET96),
        .bus        (bus.decoder),
        .gcu_ack    (gcu_ack),
        .sel_ram    (sel_ram),
        .sel_gcu    (sel_gcu),
        .sel_io     (sel_io),
        .access_new (access_new),
        .dtack_n    (dtack_n)
    );

    work_ram u_work_ram (
        .CLK96   (CLK96),
        .bus     (bus.ram),
        .sel_ram (sel_ram),
        .ram_q   (ram_q)
    );

    io_read_mux u_read_mux (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .bus          (bus.reader),
        .sel_ram      (sel_ram),
        .sel_gcu      (sel_gcu),
        .sel_io       (sel_io),
        .ram_q        (ram_q),
        .gcu_rdata    (gcu_rdata),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .soundlatch3  (soundlatch3),
        .soundlatch4  (soundlatch4),
        .hsync        (hsync),
        .vsync        (vsync),
        .fblank       (fblank),
        .vcount       (vcount),
        .eeprom_sdo   (eeprom_sdo),
        .z80_busreq   (z80_busreq),     // read back on the status port
        .rdata        (rdata)
    );

    io_write_regs u_write_regs (
        .CLK96             (CLK96),
        .RESET96           (RESET96),
        .bus               (bus.writer),
        .sel_gcu           (sel_gcu),
        .rw                (rw),
        .access_new        (access_new),
        .sel_io            (sel_io),
        .gcu_ack           (gcu_ack),
        .soundlatch        (soundlatch),
        .soundlatch2       (soundlatch2),
        .nmi               (nmi),
        .eeprom_sclk       (eeprom_sclk),
        .eeprom_sdi        (eeprom_sdi),
        .eeprom_scs        (eeprom_scs),
        .z80_busreq        (z80_busreq),
        .gcu_op_write_reg  (gcu_op_write_reg),
        .gcu_op_select_reg (gcu_op_select_reg),
        .gcu_op_write_ram  (gcu_op_write_ram),
        .gcu_op_read_h     (gcu_op_read_h),
        .gcu_op_read_l     (gcu_op_read_l),
        .gcu_op_set_ptr    (gcu_op_set_ptr)
    );

endmodule

`default_nettype wire

// File: verif/main_bus_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main bus testbench
// replays the bus trace as the CPU, answers GCU strobes as the GCU and
// checks read data, latches, EEPROM pins and strobes against the trace
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module main_bus_tb;
    import main_bus_pkg::*;

    localparam int        TIMEOUT  = 40;        // cycles per wait
    localparam cpu_data_t GCU_WORD = 16'hC0DE;  // GCU data port value

    logic       CLK96;
    logic       RESET96;
    cpu_addr_t  addr;
    cpu_data_t  wdata;
    logic       rw;
    logic       uds_n;
    logic       lds_n;
    logic       as_n;
    cpu_data_t  rdata;
    logic       dtack_n;
    logic [9:0] joystick1;
    logic [9:0] joystick2;
    logic [3:0] start_button;
    logic [3:0] coin_input;
    logic       service;
    logic       dip_test;
    byte_t      dipsw_a;
    byte_t      dipsw_b;
    byte_t      dipsw_c;
    logic       hsync;
    logic       vsync;
    logic       fblank;
    logic [8:0] vcount;
    byte_t      soundlatch3;
    byte_t      soundlatch4;
    byte_t      soundlatch;
    byte_t      soundlatch2;
    logic       nmi;
    logic       z80_busreq;
    logic       eeprom_sclk;
    logic       eeprom_sdi;
    logic       eeprom_sdo;
    logic       eeprom_scs;
    logic       gcu_ack;
    cpu_data_t  gcu_rdata;
    logic       gcu_op_write_reg;
    logic       gcu_op_select_reg;
    logic       gcu_op_write_ram;
    logic       gcu_op_read_h;
    logic       gcu_op_read_l;
    logic       gcu_op_set_ptr;

    logic [5:0] strobes;
    logic [1:0] ack_cnt;

    // fields of the current trace line
    int          t_id;
    logic [15:0] op;
    logic [23:0] byte_addr;
    logic [15:0] wr_data;
    logic [1:0]  lanes;        // bit 1 upper, bit 0 lower
    logic [11:0] joy1;
    logic [11:0] joy2;
    logic [15:0] sys;
    logic [23:0] dip;
    logic [23:0] vid;
    logic [23:0] aux;
    logic [15:0] exp_val;

    logic [8*128-1:0] text_line;
    int fd;
    int code;
    int cur_test    = 0;
    int checks      = 0;
    int errors      = 0;
    int test_checks = 0;
    int test_errors = 0;
    int nmi_cycles  = 0;
    int sl_writes   = 0;

    main_bus dut (.*);

    initial CLK96 = 1'b0;
    always #4 CLK96 = ~CLK96;

    assign strobes = {gcu_op_set_ptr, gcu_op_read_l, gcu_op_read_h,
                      gcu_op_write_ram, gcu_op_select_reg, gcu_op_write_reg};

    // GCU model, acks a few cycles after any strobe and drops with it
    always @(posedge CLK96) begin
        if (RESET96 || strobes == 6'd0) begin
            gcu_ack <= 1'b0;
            ack_cnt <= 2'd0;
        end else if (ack_cnt == 2'd2) begin
            gcu_ack <= 1'b1;
        end else begin
            ack_cnt <= ack_cnt + 2'd1;
        end
    end

    always @(negedge CLK96) begin
        if (nmi === 1'b1) begin
            nmi_cycles++;
        end
    end

    function automatic string test_name(input int t);
        case (t)
            1:       test_name = "ram byte lanes";
            2:       test_name = "cabinet and dip reads";
            3:       test_name = "video status";
            4:       test_name = "sound latches";
            5:       test_name = "eeprom port";
            6:       test_name = "gcu accesses";
            default: test_name = "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        test_checks++;
        assert (actual === expected) else begin
            $display("ERROR %s expected %h got %h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("test %0d: %s", cur_test, what);
        errors++;
        test_errors++;
    endtask

    task automatic close_test;
        if (cur_test != 0) begin
            $display("test %0d %s: %0d checks, %0d errors", cur_test,
                     test_name(cur_test), test_checks, test_errors);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic wait_dtack(output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < TIMEOUT) begin
            @(negedge CLK96);
            ok = !dtack_n;
            n++;
        end
    endtask

    // strobe must rise alone, hold until the ack, then drop with dtack_n
    task automatic gcu_cycle;
        int   n;
        logic ok;
        logic held;
        logic ack_seen;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < TIMEOUT) begin
            @(negedge CLK96);
            ok = strobes != 6'd0;
            n++;
        end
        assert (ok) else report_problem("no GCU strobe within 40 cycles");
        check_value("gcu strobes", exp_val, {10'd0, strobes});
        check_value("dtack_n", 16'h0001, {15'd0, dtack_n});
        held     = 1'b1;
        ack_seen = 1'b0;
        ok       = 1'b0;
        n        = 0;
        while (!ok && n < TIMEOUT) begin
            @(negedge CLK96);
            ok = !dtack_n;
            if (!ok) begin
                if (!ack_seen) begin
                    held = held && strobes == exp_val[5:0];
                end
                ack_seen = ack_seen || gcu_ack;
            end
            n++;
        end
        assert (ok) else report_problem("no data acknowledge after the GCU strobe");
        assert (held) else report_problem("GCU strobe changed before the acknowledge");
        assert (ack_seen) else report_problem("data acknowledge came before the GCU ack");
        check_value("gcu strobes", 16'h0000, {10'd0, strobes});
    endtask

    task automatic run_line;
        logic ok;
        @(posedge CLK96);
        joystick1    <= joy1[9:0];
        joystick2    <= joy2[9:0];
        start_button <= sys[15:12];
        coin_input   <= sys[11:8];
        dip_test     <= sys[4];
        service      <= sys[0];
        dipsw_c      <= dip[23:16];
        dipsw_b      <= dip[15:8];
        dipsw_a      <= dip[7:0];
        hsync        <= vid[20];
        vsync        <= vid[16];
        fblank       <= vid[12];
        vcount       <= vid[8:0];
        eeprom_sdo   <= aux[20];
        soundlatch4  <= aux[15:8];
        soundlatch3  <= aux[7:0];
        addr         <= byte_addr[23:1];
        wdata        <= wr_data;
        rw           <= (op == "rd" || op == "gr");
        uds_n        <= !lanes[1];
        lds_n        <= !lanes[0];
        as_n         <= 1'b0;
        if (op == "gw" || op == "gr") begin
            gcu_cycle();
            if (op == "gr") begin
                check_value("rdata", GCU_WORD, rdata);
            end
        end else begin
            wait_dtack(ok);
            assert (ok) else report_problem("no data acknowledge within 40 cycles");
            if (op == "rd") begin
                check_value("rdata", exp_val, rdata);
            end
            if (op == "sl") begin
                sl_writes++;
                if (byte_addr[7:0] == 8'h14) begin
                    check_value("soundlatch", exp_val, {8'h00, soundlatch});
                end else begin
                    check_value("soundlatch2", exp_val, {8'h00, soundlatch2});
                end
                check_value("nmi", 16'h0001, {15'd0, nmi});    // edge 2
            end
            if (op == "ee") begin
                check_value("z80_busreq/eeprom_sclk/eeprom_sdi/eeprom_scs", exp_val,
                            {11'd0, z80_busreq, eeprom_sclk, eeprom_sdi, 1'b0, eeprom_scs});
            end
        end
        @(posedge CLK96);
        as_n  <= 1'b1;
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        if (op == "sl") begin
            @(negedge CLK96);
            check_value("nmi", 16'h0000, {15'd0, nmi});    // pulse gone after one cycle
        end
    endtask

    initial begin
        RESET96      = 1'b1;
        addr         = '0;
        wdata        = '0;
        rw           = 1'b1;
        uds_n        = 1'b1;
        lds_n        = 1'b1;
        as_n         = 1'b1;
        joystick1    = '1;     // active low, released
        joystick2    = '1;
        start_button = '1;
        coin_input   = '1;
        service      = 1'b1;
        dip_test     = 1'b1;
        dipsw_a      = '0;
        dipsw_b      = '0;
        dipsw_c      = '0;
        hsync        = 1'b0;
        vsync        = 1'b0;
        fblank       = 1'b0;
        vcount       = '0;
        soundlatch3  = '0;
        soundlatch4  = '0;
        eeprom_sdo   = 1'b0;
        gcu_ack      = 1'b0;
        ack_cnt      = 2'd0;
        gcu_rdata    = GCU_WORD;

        repeat (4) @(posedge CLK96);
        RESET96 <= 1'b0;

        fd = $fopen("verif/main_bus_trace.txt", "r");
        assert (fd != 0) else report_problem("cannot open verif/main_bus_trace.txt");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                text_line = '0;
                code = $fgets(text_line, fd);
                if (code != 0) begin
                    // comment lines fail to parse and are skipped
                    code = $sscanf(text_line, "%d %s %h %h %h %h %h %h %h %h %h %h",
                                   t_id, op, byte_addr, wr_data, lanes, joy1, joy2,
                                   sys, dip, vid, aux, exp_val);
                    if (code == 12) begin
                        if (t_id != cur_test) begin
                            close_test();
                            cur_test = t_id;
                        end
                        run_line();
                    end
                end
            end
            $fclose(fd);
            close_test();
        end

        check_value("nmi cycles", sl_writes[15:0], nmi_cycles[15:0]);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/main_bus_trace.txt
# test op byte_addr wdata lanes(2 upper,1 lower) joy1 joy2 sys(start,coin,test,service)
# dip(c,b,a) vid(hsync,vsync,fblank,vcount) aux(sdo,-,sl4,sl3) expected, all hex
1 wr 208000 1234 3 3ff 3ff ff11 000000 000000 000000 0000
1 wr 20fffe abcd 3 3ff 3ff ff11 000000 000000 000000 0000
1 wr 208000 5600 2 3ff 3ff ff11 000000 000000 000000 0000
1 wr 20fffe 00ef 1 3ff 3ff ff11 000000 000000 000000 0000
1 rd 208000 0000 3 3ff 3ff ff11 000000 000000 000000 5634
1 rd 20fffe 0000 3 3ff 3ff ff11 000000 000000 000000 abef
2 rd 500000 0000 3 3fe 3ef ff11 000000 000000 000000 1008
2 rd 500000 0000 3 000 3ff ff11 000000 000000 000000 007f
2 rd 500000 0000 3 3b7 3f9 ff11 000000 000000 000000 0641
2 rd 500002 0000 3 3ff 3ff ed01 5a0000 000000 000000 5a34
2 rd 500002 0000 3 3ff 3ff de10 c30000 000000 000000 c349
2 rd 500004 0000 3 3ff 3ff ff11 00a53c 000000 000000 a53c
3 rd 500006 0000 3 3ff 3ff ff11 000000 000080 000000 3e80
3 rd 500006 0000 3 3ff 3ff ff11 000000 1010ff 000000 bfff
3 rd 500006 0000 3 3ff 3ff ff11 000000 011100 000000 7fff
3 rd 500006 0000 3 3ff 3ff ff11 000000 110105 000000 feff
4 sl 500014 12a5 1 3ff 3ff ff11 000000 000000 000000 00a5
4 sl 500016 003c 3 3ff 3ff ff11 000000 000000 000000 003c
4 rd 500010 0000 3 3ff 3ff ff11 000000 000000 00c35a 005a
4 rd 500012 0000 3 3ff 3ff ff11 000000 000000 00c35a 00c3
5 ee 50001e 001d 1 3ff 3ff ff11 000000 000000 000000 001d
5 ee 50001e 00f6 1 3ff 3ff ff11 000000 000000 000000 0014
5 rd 500018 0000 3 3ff 3ff ff11 000000 000000 100000 0011
5 ee 50001e 0009 1 3ff 3ff ff11 000000 000000 000000 0009
5 rd 500018 0000 3 3ff 3ff ff11 000000 000000 000000 0000
6 gw 400000 1111 3 3ff 3ff ff11 000000 000000 000000 0001
6 gw 400004 2222 3 3ff 3ff ff11 000000 000000 000000 0002
6 gw 400008 3333 3 3ff 3ff ff11 000000 000000 000000 0004
6 gw 40000a 4444 3 3ff 3ff ff11 000000 000000 000000 0004
6 gw 40000c 5555 3 3ff 3ff ff11 000000 000000 000000 0020
6 gr 400008 0000 3 3ff 3ff ff11 000000 000000 000000 0008
6 gr 40000a 0000 3 3ff 3ff ff11 000000 000000 000000 0010

// File: main_bus.f
source/main_bus_pkg.sv
source/cpu_bus_if.sv
source/address_decoder.sv
source/work_ram.sv
source/io_read_mux.sv
source/io_write_regs.sv
source/main_bus.sv
verif/main_bus_tb.sv
